/* hw/csr_consts.svh */
//////////////////////////////////////////////////
// widths, addresses, status bits and cause codes of the CSR file
// status bits are 64-bit masks, not bit indexes
// only the eight supported CSRs have an address here
//////////////////////////////////////////////////
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// widths
`define CSR_ADDR_W    12
`define CSR_DATA_W    64
// retire count of 0 to 4
`define COMMIT_CNT_W  3
`define CAUSE_W       5

// CSR numbers
`define ADDR_FFLAGS   12'h001
`define ADDR_FRM      12'h002
`define ADDR_EPC      12'h502
`define ADDR_BADVADDR 12'h503
`define ADDR_COUNT    12'h506
`define ADDR_EVEC     12'h508
`define ADDR_CAUSE    12'h509
`define ADDR_STATUS   12'h50a

// status fields
`define SR_S          64'h0000_0000_0000_0001
`define SR_PS         64'h0000_0000_0000_0002
`define SR_EI         64'h0000_0000_0000_0004
`define SR_PEI        64'h0000_0000_0000_0008
`define SR_EF         64'h0000_0000_0000_0010
`define SR_U64        64'h0000_0000_0000_0020
`define SR_S64        64'h0000_0000_0000_0040
`define SR_EA         64'h0000_0000_0000_0100

`define STATUS_RESET  (`SR_S | `SR_U64 | `SR_S64 | `SR_EF)

// software may touch only the named low bits, EA stays read-only
`define STATUS_WR_MASK ((`SR_S | `SR_PS | `SR_EI | `SR_PEI | `SR_EF | `SR_U64 | `SR_S64) \
                        & ~`SR_EA & 64'h0000_0000_ffff_ffff)
`define FFLAGS_MASK   64'h0000_0000_ffff_ffff
`define FRM_MASK      64'h0000_0000_ffff_ffff

// exception causes that load badvaddr
`define CAUSE_MISALIGNED_FETCH 5'd0
`define CAUSE_FAULT_FETCH      5'd1
`define CAUSE_MISALIGNED_LOAD  5'd4
`define CAUSE_FAULT_LOAD       5'd5
`define CAUSE_MISALIGNED_STORE 5'd6
`define CAUSE_FAULT_STORE      5'd7

`endif

/* hw/csr_pkg.sv */
//////////////////////////////////////////////////
// register-file side types of the CSR file
// csr_state_t holds all eight live registers
//////////////////////////////////////////////////
`include "csr_consts.svh"

package csr_pkg;

  // CSR number and register value
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CSR_DATA_W-1:0] csr_data_t;

  // staged or committing software write
  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    csr_data_t data;
  } csr_wr_t;

  // live architectural registers, fed to the read unit
  typedef struct packed {
    csr_data_t fflags;
    csr_data_t frm;
    csr_data_t epc;
    csr_data_t badvaddr;
    csr_data_t evec;
    csr_data_t cause;
    csr_data_t count;
    csr_data_t status;
  } csr_state_t;

endpackage

/* hw/trap_pkg.sv */
//////////////////////////////////////////////////
// retirement side types, exception and commit count
//////////////////////////////////////////////////
`include "csr_consts.svh"

package trap_pkg;

  typedef logic [`COMMIT_CNT_W-1:0] commit_cnt_t;
  typedef logic [`CAUSE_W-1:0]      cause_t;
  typedef logic [`CSR_DATA_W-1:0]   vaddr_t;

  // exception retiring this cycle
  typedef struct packed {
    logic   flag;
    cause_t cause;
    vaddr_t pc;
    // addresses of the committing load and store
    vaddr_t ld_addr;
    vaddr_t st_addr;
  } exc_info_t;

endpackage

/* hw/csr_commit_buffer.sv */
//////////////////////////////////////////////////
// holds one CSR write until its instruction commits
// assumes a single CSR instruction in flight
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_commit_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en_i,
  input  csr_pkg::csr_addr_t  wr_addr_i,
  input  csr_pkg::csr_data_t  wr_data_i,
  input  logic                commit_i,
  input  logic                flush_i,
  output csr_pkg::csr_wr_t    commit_wr_o
);
  import csr_pkg::*;

  // staged payload, only meaningful while pending is set
  csr_addr_t stage_addr;
  csr_data_t stage_data;
  logic      pending;

  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      stage_addr <= wr_addr_i;
      stage_data <= wr_data_i;
    end
  end

  // a new write beats a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pending <= 1'b0;
    else if (wr_en_i)
      pending <= 1'b1;
    else if (flush_i)
      pending <= 1'b0;
  end

  // write goes out only in the commit cycle
  assign commit_wr_o.valid = commit_i & pending;
  assign commit_wr_o.addr  = stage_addr;
  assign commit_wr_o.data  = stage_data;

endmodule

/* hw/csr_trap_regs.sv */
//////////////////////////////////////////////////
// exception capture registers and the retire counter
// a committed software write wins over the hardware update
// badvaddr moves only for fetch, load and store causes
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_trap_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_wr_t     commit_wr_i,
  input  trap_pkg::exc_info_t  exc_i,
  input  trap_pkg::commit_cnt_t retire_cnt_i,
  output csr_pkg::csr_data_t   epc_o,
  output csr_pkg::csr_data_t   cause_o,
  output csr_pkg::csr_data_t   badvaddr_o,
  output csr_pkg::csr_data_t   evec_o,
  output csr_pkg::csr_data_t   count_o
);
  import csr_pkg::*;
  import trap_pkg::*;

  csr_data_t epc_q;
  csr_data_t cause_q;
  csr_data_t badvaddr_q;
  csr_data_t evec_q;
  csr_data_t count_q;
  vaddr_t    badvaddr_next;
  csr_data_t count_next;

  // badvaddr source picked by the cause
  always_comb
  begin
    badvaddr_next = badvaddr_q;
    if (exc_i.flag)
    begin
      case (exc_i.cause)
        `CAUSE_MISALIGNED_FETCH, `CAUSE_FAULT_FETCH: badvaddr_next = exc_i.pc;
        `CAUSE_MISALIGNED_LOAD,  `CAUSE_FAULT_LOAD:  badvaddr_next = exc_i.ld_addr;
        `CAUSE_MISALIGNED_STORE, `CAUSE_FAULT_STORE: badvaddr_next = exc_i.st_addr;
        default:                                     badvaddr_next = badvaddr_q;
      endcase
    end
  end

  // an exception also counts as one retired slot
  assign count_next = count_q
                    + {{(`CSR_DATA_W-`COMMIT_CNT_W){1'b0}}, retire_cnt_i}
                    + {{(`CSR_DATA_W-1){1'b0}}, exc_i.flag};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      epc_q      <= '0;
      cause_q    <= '0;
      badvaddr_q <= '0;
      evec_q     <= '0;
      count_q    <= '0;
    end
    else
    begin
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_EPC)
        epc_q <= commit_wr_i.data;
      else if (exc_i.flag)
        epc_q <= exc_i.pc;
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_CAUSE)
        cause_q <= commit_wr_i.data;
      else if (exc_i.flag)
        cause_q <= {{(`CSR_DATA_W-`CAUSE_W){1'b0}}, exc_i.cause};
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_BADVADDR)
        badvaddr_q <= commit_wr_i.data;
      else
        badvaddr_q <= badvaddr_next;
      // evec is software only
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_EVEC)
        evec_q <= commit_wr_i.data;
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_COUNT)
        count_q <= commit_wr_i.data;
      else
        count_q <= count_next;
    end
  end

  assign epc_o      = epc_q;
  assign cause_o    = cause_q;
  assign badvaddr_o = badvaddr_q;
  assign evec_o     = evec_q;
  assign count_o    = count_q;

endmodule

/* hw/csr_status_reg.sv */
//////////////////////////////////////////////////
// supervisor status register
// software writes are masked, EA and unnamed bits stay zero
// sret pops PS into S and PEI into EI
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_status_reg (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_wr_t   commit_wr_i,
  input  logic               sret_i,
  output csr_pkg::csr_data_t status_o
);
  import csr_pkg::*;

  csr_data_t status_q;
  csr_data_t sret_val;
  logic      wr_status;

  assign wr_status = commit_wr_i.valid && (commit_wr_i.addr == `ADDR_STATUS);

  // clear S and EI, then restore them from the saved copies
  always_comb
  begin
    sret_val = status_q & ~(`SR_S | `SR_EI);
    if (|(status_q & `SR_PS))
      sret_val = sret_val | `SR_S;
    if (|(status_q & `SR_PEI))
      sret_val = sret_val | `SR_EI;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      status_q <= `STATUS_RESET;
    end
    else if (wr_status)
    begin
      // software write has priority over sret
      status_q <= commit_wr_i.data & `STATUS_WR_MASK;
    end
    else if (sret_i)
    begin
      status_q <= sret_val;
    end
  end

  assign status_o = status_q;

endmodule

/* hw/csr_fp_regs.sv */
//////////////////////////////////////////////////
// floating-point flags and rounding mode
// fflags collects sticky flags from retiring FP ops
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_fp_regs (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_wr_t   commit_wr_i,
  input  csr_pkg::csr_data_t fflags_i,
  output csr_pkg::csr_data_t fflags_o,
  output csr_pkg::csr_data_t frm_o
);
  import csr_pkg::*;

  csr_data_t fflags_q;
  csr_data_t frm_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fflags_q <= '0;
      frm_q    <= '0;
    end
    else
    begin
      // a write replaces the flags, pulses in that cycle are lost
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_FFLAGS)
        fflags_q <= commit_wr_i.data & `FFLAGS_MASK;
      else
        fflags_q <= fflags_q | (fflags_i & `FFLAGS_MASK);
      if (commit_wr_i.valid && commit_wr_i.addr == `ADDR_FRM)
        frm_q <= commit_wr_i.data & `FRM_MASK;
    end
  end

  assign fflags_o = fflags_q;
  assign frm_o    = frm_q;

endmodule

/* hw/csr_read_check.sv */
//////////////////////////////////////////////////
// combinational CSR read and atomicity check
// unmapped addresses read zero and never flag
// checkpoint dropped on flush or commit
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_read_check (
  input  logic                clk,
  input  logic                reset,
  input  csr_pkg::csr_state_t state_i,
  input  logic                rd_en_i,
  input  csr_pkg::csr_addr_t  rd_addr_i,
  input  logic                flush_i,
  input  logic                commit_i,
  output csr_pkg::csr_data_t  rd_data_o,
  output logic                atomic_vio_o
);
  import csr_pkg::*;

  csr_addr_t chk_addr;
  csr_data_t chk_data;
  logic      chk_valid;

  // address decode shared by the read port and the checker
  function automatic csr_data_t sel_reg(input csr_state_t st, input csr_addr_t addr);
    case (addr)
      `ADDR_FFLAGS:   sel_reg = st.fflags;
      `ADDR_FRM:      sel_reg = st.frm;
      `ADDR_EPC:      sel_reg = st.epc;
      `ADDR_BADVADDR: sel_reg = st.badvaddr;
      `ADDR_COUNT:    sel_reg = st.count;
      `ADDR_EVEC:     sel_reg = st.evec;
      `ADDR_CAUSE:    sel_reg = st.cause;
      `ADDR_STATUS:   sel_reg = st.status;
      default:        sel_reg = '0;
    endcase
  endfunction

  assign rd_data_o = sel_reg(state_i, rd_addr_i);

  // snapshot of what the CSR instruction saw
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chk_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chk_valid <= 1'b1;
      chk_addr  <= rd_addr_i;
      chk_data  <= rd_data_o;
    end
    else if (flush_i || commit_i)
    begin
      chk_valid <= 1'b0;
    end
  end

  // unmapped checkpoint holds zero and reselects zero, so no flag
  assign atomic_vio_o = chk_valid && (sel_reg(state_i, chk_addr) != chk_data);

endmodule

/* hw/csr_file.sv */
//////////////////////////////////////////////////
// supervisor CSR file top
// writes take effect only at commit, reads are combinational
// no back-pressure, one CSR instruction in flight
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_file (
  input  logic                  clk,
  input  logic                  reset,
  // software write path
  input  logic                  wr_en_i,
  input  csr_pkg::csr_addr_t    wr_addr_i,
  input  csr_pkg::csr_data_t    wr_data_i,
  input  logic                  commit_i,
  input  logic                  flush_i,
  // read path
  input  logic                  rd_en_i,
  input  csr_pkg::csr_addr_t    rd_addr_i,
  output csr_pkg::csr_data_t    rd_data_o,
  output logic                  atomic_vio_o,
  // retirement side
  input  trap_pkg::exc_info_t   exc_i,
  input  trap_pkg::commit_cnt_t retire_cnt_i,
  input  logic                  sret_i,
  input  csr_pkg::csr_data_t    fflags_i,
  // live values for the pipeline
  output csr_pkg::csr_data_t    epc_o,
  output csr_pkg::csr_data_t    evec_o,
  output csr_pkg::csr_data_t    status_o,
  output csr_pkg::csr_data_t    frm_o
);
  import csr_pkg::*;

  csr_wr_t    commit_wr;
  // each unit fills its own fields
  csr_state_t state;

  csr_commit_buffer u_commit_buffer (
    .clk(clk), .reset(reset),
    .wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .commit_i(commit_i), .flush_i(flush_i), .commit_wr_o(commit_wr)
  );

  csr_trap_regs u_trap_regs (
    .clk(clk), .reset(reset), .commit_wr_i(commit_wr),
    .exc_i(exc_i), .retire_cnt_i(retire_cnt_i),
    .epc_o(state.epc), .cause_o(state.cause), .badvaddr_o(state.badvaddr),
    .evec_o(state.evec), .count_o(state.count)
  );

  csr_status_reg u_status_reg (
    .clk(clk), .reset(reset), .commit_wr_i(commit_wr),
    .sret_i(sret_i), .status_o(state.status)
  );

  csr_fp_regs u_fp_regs (
    .clk(clk), .reset(reset), .commit_wr_i(commit_wr),
    .fflags_i(fflags_i), .fflags_o(state.fflags), .frm_o(state.frm)
  );

  csr_read_check u_read_check (
    .clk(clk), .reset(reset), .state_i(state),
    .rd_en_i(rd_en_i), .rd_addr_i(rd_addr_i),
    .flush_i(flush_i), .commit_i(commit_i),
    .rd_data_o(rd_data_o), .atomic_vio_o(atomic_vio_o)
  );

  assign epc_o    = state.epc;
  assign evec_o   = state.evec;
  assign status_o = state.status;
  assign frm_o    = state.frm;

endmodule

/* sim/csr_file_tb.sv */
//////////////////////////////////////////////////
// self-checking testbench of the CSR file, driven by a pattern file
// patterns read from sim/csr_patterns.txt, run from the project root
// badvaddr model follows exceptions only, no software writes to it
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_file_tb;
  import csr_pkg::*;
  import trap_pkg::*;

  localparam int clk_period = 8;

  logic        clk = 1'b0;
  logic        reset;
  logic        wr_en_i, commit_i, flush_i, rd_en_i, sret_i;
  csr_addr_t   wr_addr_i, rd_addr_i;
  csr_data_t   wr_data_i, fflags_i;
  exc_info_t   exc_i;
  commit_cnt_t retire_cnt_i;
  csr_data_t   rd_data_o, epc_o, evec_o, status_o, frm_o;
  logic        atomic_vio_o;

  // parsed pattern lines
  string     ops[$];
  string     names[$];
  csr_data_t f_addr[$], f_data[$], f_exp[$];
  int        n_lines = 0;
  int        n_checks = 0;
  int        data_errs = 0;
  int        flag_errs = 0;
  int        other_errs = 0;
  // badvaddr as the cause rule leaves it, zero after reset
  csr_data_t bad_model = '0;

  csr_file dut_i (
    .clk(clk), .reset(reset),
    .wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .commit_i(commit_i), .flush_i(flush_i),
    .rd_en_i(rd_en_i), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
    .atomic_vio_o(atomic_vio_o),
    .exc_i(exc_i), .retire_cnt_i(retire_cnt_i), .sret_i(sret_i), .fflags_i(fflags_i),
    .epc_o(epc_o), .evec_o(evec_o), .status_o(status_o), .frm_o(frm_o)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
    n_checks++;
    if (act !== exp)
    begin
      data_errs++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp)
    begin
      flag_errs++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // every per-cycle input back to idle
  task automatic clear_inputs();
    wr_en_i      = 1'b0;
    wr_addr_i    = '0;
    wr_data_i    = '0;
    commit_i     = 1'b0;
    flush_i      = 1'b0;
    rd_en_i      = 1'b0;
    rd_addr_i    = '0;
    exc_i        = '0;
    retire_cnt_i = '0;
    sret_i       = 1'b0;
    fflags_i     = '0;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic start_cycle();
    @(posedge clk);
    #1;
    clear_inputs();
  endtask

  task automatic read_and_check(input string name, input csr_addr_t addr, input csr_data_t exp);
    start_cycle();
    rd_en_i   = 1'b1;
    rd_addr_i = addr;
    #2;
    check_data(name, exp, rd_data_o);
  endtask

  // one retiring exception, then readback of the captured registers
  task automatic run_exception(input string name, input cause_t cause,
                               input commit_cnt_t cnt, input csr_data_t exp_count);
    vaddr_t pc;
    vaddr_t ld;
    vaddr_t st;
    pc = {$urandom, $urandom};
    ld = {$urandom, $urandom};
    st = {$urandom, $urandom};
    start_cycle();
    exc_i.flag    = 1'b1;
    exc_i.cause   = cause;
    exc_i.pc      = pc;
    exc_i.ld_addr = ld;
    exc_i.st_addr = st;
    retire_cnt_i  = cnt;
    // fetch causes take the pc, loads and stores their own address
    if (cause == `CAUSE_MISALIGNED_FETCH || cause == `CAUSE_FAULT_FETCH)
      bad_model = pc;
    else if (cause == `CAUSE_MISALIGNED_LOAD || cause == `CAUSE_FAULT_LOAD)
      bad_model = ld;
    else if (cause == `CAUSE_MISALIGNED_STORE || cause == `CAUSE_FAULT_STORE)
      bad_model = st;
    read_and_check({name, " cause"}, `ADDR_CAUSE, csr_data_t'(cause));
    check_data({name, " epc_o"}, pc, epc_o);
    read_and_check({name, " epc"}, `ADDR_EPC, pc);
    read_and_check({name, " badvaddr"}, `ADDR_BADVADDR, bad_model);
    read_and_check({name, " count"}, `ADDR_COUNT, exp_count);
    // drop the checkpoint left by the readback
    start_cycle();
    flush_i = 1'b1;
  endtask

  // op addr data expect, lines starting with # are skipped
  task automatic load_patterns();
    int        fd;
    int        code;
    int        line_no;
    string     op;
    string     rest;
    csr_data_t a, d, e;
    line_no = 0;
    fd = $fopen("sim/csr_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file sim/csr_patterns.txt");
      other_errs++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fscanf(fd, "%s", op);
        if (code == 1)
        begin
          line_no++;
          if (op.substr(0, 0) == "#")
            code = $fgets(rest, fd);
          else
          begin
            code = $fscanf(fd, "%h %h %h", a, d, e);
            if (code != 3)
            begin
              $display("pattern line %0d is malformed", line_no);
              other_errs++;
            end
            ops.push_back(op);
            names.push_back($sformatf("line %0d %s %h", line_no, op, a[11:0]));
            f_addr.push_back(a);
            f_data.push_back(d);
            f_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // watchdog, scaled by the number of pattern lines
  initial
  begin
    wait (n_lines > 0);
    #(n_lines * clk_period * 4);
    $display("timeout: the pattern run did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial
  begin
    int        i;
    string     op;
    string     name;
    csr_data_t a, d, e;
    void'($urandom(35983));
    reset = 1'b1;
    clear_inputs();
    load_patterns();
    n_lines = ops.size();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    for (i = 0; i < n_lines; i++)
    begin
      op   = ops[i];
      name = names[i];
      a    = f_addr[i];
      d    = f_data[i];
      e    = f_exp[i];
      if (op == "write")
      begin
        start_cycle();
        wr_en_i   = 1'b1;
        wr_addr_i = a[11:0];
        wr_data_i = d;
      end
      else if (op == "commit")
      begin
        start_cycle();
        commit_i = 1'b1;
      end
      else if (op == "flush")
      begin
        start_cycle();
        flush_i = 1'b1;
      end
      else if (op == "read")
      begin
        // data bit 0 commits in the same cycle
        start_cycle();
        rd_en_i   = 1'b1;
        rd_addr_i = a[11:0];
        commit_i  = d[0];
        #2;
        check_data(name, e, rd_data_o);
        // live outputs carry the same register value
        if (a[11:0] == `ADDR_STATUS)
          check_data({name, " status_o"}, e, status_o);
        if (a[11:0] == `ADDR_FRM)
          check_data({name, " frm_o"}, e, frm_o);
        if (a[11:0] == `ADDR_EVEC)
          check_data({name, " evec_o"}, e, evec_o);
      end
      else if (op == "exception")
        run_exception(name, a[4:0], d[2:0], e);
      else if (op == "sret")
      begin
        start_cycle();
        sret_i = 1'b1;
      end
      else if (op == "fflags")
      begin
        // addr bit 0 commits in the same cycle
        start_cycle();
        fflags_i = d;
        commit_i = a[0];
      end
      else if (op == "idle")
      begin
        start_cycle();
        retire_cnt_i = d[2:0];
        #2;
        check_flag(name, e[0], atomic_vio_o);
      end
      else
      begin
        $display("unknown opcode %s on %s", op, name);
        other_errs++;
      end
    end
    start_cycle();
    if (data_errs == 0 && flag_errs == 0 && other_errs == 0)
      $display("No errors");
    else
      $display("Errors found");
    $display("%0d checks, %0d data mismatches, %0d flag mismatches, %0d other failures",
             n_checks, data_errs, flag_errs, other_errs);
    $finish;
  end

endmodule

/* sim/csr_patterns.txt */
# op addr data expect, hex; read data 1 and fflags addr 1 commit in the same cycle
# exception addr is the cause, data the retire count, expect the count; idle expect is the flag
read 50a 0 71
write 50a ffffffffffffffff 0
commit 0 0 0
read 50a 0 7f
write 50a a 0
commit 0 0 0
sret 0 0 0
read 50a 0 f
write 50a 5 0
commit 0 0 0
sret 0 0 0
read 50a 0 0
write 508 80001000 0
read 508 0 0
commit 0 0 0
read 508 0 80001000
write 508 dead 0
flush 0 0 0
commit 0 0 0
read 508 0 80001000
fflags 0 1 0
fflags 0 4 0
read 001 0 5
write 001 ff00000000000010 0
fflags 1 8 0
read 001 0 10
write 002 ffffffffffffffff 0
commit 0 0 0
read 002 0 ffffffff
exception 0 2 3
exception 1 0 4
exception 4 3 8
exception 5 1 a
exception 6 4 f
exception 7 0 10
exception 2 2 13
idle 0 3 0
read 506 0 16
idle 0 0 0
read 7ff 0 0
idle 0 0 0
write 509 1f 0
read 509 1 2
idle 0 0 1
flush 0 0 0
idle 0 0 0
read 509 0 1f

/* project.f */
+incdir+hw
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_commit_buffer.sv
hw/csr_trap_regs.sv
hw/csr_status_reg.sv
hw/csr_fp_regs.sv
hw/csr_read_check.sv
hw/csr_file.sv
sim/csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the CSR file testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/10ps -f project.f \
  --top-module csr_file_tb -o csr_file_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/csr_file_tb_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

# pass only when the testbench reported a clean run
if grep -q "^No errors$" "$log"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
